// File: mips_pkg.sv
// mips pipeline package with word types, the instruction views, and the stage register layouts.
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// opcodes of the supported subset.
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20; // r-type function codes.
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [15:0] imm;
	} i_fields_t;

	// the same instruction word, seen as r-type or i-type.
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		logic regdst; // write rd instead of rt.
		logic alusrc; // second operand is the immediate.
		alu_op_e aluop;
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic memread;
		logic memwrite;
	} mem_ctrl_t;

	typedef struct packed {
		logic regwrite;
		logic memtoreg; // write back the loaded word.
	} wb_ctrl_t;

	typedef struct packed {
		word_t next_pc;
		word_t instruction;
	} if_id_t;

	typedef struct packed {
		ex_ctrl_t ex_ctrl;
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t wb_ctrl;
		word_t next_pc;
		word_t rs_data;
		word_t rt_data;
		word_t imm;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		mem_ctrl_t mem_ctrl;
		wb_ctrl_t wb_ctrl;
		word_t branch_target;
		logic zero;
		word_t alu_result;
		word_t rt_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		wb_ctrl_t wb_ctrl;
		word_t mem_data;
		word_t alu_result;
		reg_addr_t dest;
	} mem_wb_t;

endpackage

// File: fetch.sv
// instruction fetch stage holding the program counter and the IF/ID register.
`timescale 1ns/1ps

module fetch import mips_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic i_clk,
	input logic i_reset,
	input word_t i_branch_target,
	input logic i_pc_src,
	input word_t i_instruction,

	output word_t o_pc,
	output if_id_t o_if_id
);

	word_t pc_plus4;

	assign pc_plus4 = o_pc + 32'd4;

	// a resolved branch overrides the sequential address.
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_pc <= RESET_PC;
		end else if (i_pc_src) begin
			o_pc <= i_branch_target;
		end else begin
			o_pc <= pc_plus4;
		end
	end

	always_ff @(posedge i_clk) begin
		o_if_id.next_pc <= pc_plus4;
		if (i_reset) begin
			o_if_id.instruction <= '0; // an all-zero word decodes as a nop.
		end else begin
			o_if_id.instruction <= i_instruction;
		end
	end

	// branch targets come from execute, so this also covers the target adder.
	a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
		o_pc[1:0] == 2'b00);

endmodule

// File: decode.sv
// instruction decode stage with control generation, the register file and the ID/EX register.
`timescale 1ns/1ps

module decode import mips_pkg::*; (
	input logic i_clk,
	input logic i_reset,
	input if_id_t i_if_id,
	input logic i_wb_regwrite,
	input reg_addr_t i_wb_reg,
	input word_t i_wb_data,

	output id_ex_t o_id_ex
);

	instr_u instr;
	ex_ctrl_t ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t wb_ctrl;
	word_t regs [32];
	word_t rs_data;
	word_t rt_data;
	word_t imm_ext;

	assign instr = i_if_id.instruction;
	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

	always_comb begin
		ex_ctrl = '0;
		mem_ctrl = '0;
		wb_ctrl = '0;
		case (instr.r.opcode)
			OP_RTYPE: begin
				ex_ctrl.regdst = 1'b1;
				wb_ctrl.regwrite = 1'b1;
				case (instr.r.funct)
					FN_ADD: ex_ctrl.aluop = ALU_ADD;
					FN_SUB: ex_ctrl.aluop = ALU_SUB;
					FN_AND: ex_ctrl.aluop = ALU_AND;
					FN_OR: ex_ctrl.aluop = ALU_OR;
					FN_SLT: ex_ctrl.aluop = ALU_SLT;
					default: wb_ctrl.regwrite = 1'b0; // unknown funct falls through as a nop.
				endcase
			end
			OP_ADDI: begin
				ex_ctrl.alusrc = 1'b1;
				wb_ctrl.regwrite = 1'b1;
			end
			OP_LW: begin
				ex_ctrl.alusrc = 1'b1;
				mem_ctrl.memread = 1'b1;
				wb_ctrl.regwrite = 1'b1;
				wb_ctrl.memtoreg = 1'b1;
			end
			OP_SW: begin
				ex_ctrl.alusrc = 1'b1;
				mem_ctrl.memwrite = 1'b1;
			end
			OP_BEQ: begin
				ex_ctrl.aluop = ALU_SUB; // equal operands give a zero difference.
				mem_ctrl.branch = 1'b1;
			end
			default: ;
		endcase
	end

	// register zero is never written, so it keeps its reset value.
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_regwrite && i_wb_reg != '0) begin
			regs[i_wb_reg] <= i_wb_data;
		end
	end

	// A write in this cycle is passed straight to the readers.
	always_comb begin
		rs_data = regs[instr.r.rs];
		rt_data = regs[instr.r.rt];
		if (i_wb_regwrite && i_wb_reg != '0 && i_wb_reg == instr.r.rs) begin
			rs_data = i_wb_data;
		end
		if (i_wb_regwrite && i_wb_reg != '0 && i_wb_reg == instr.r.rt) begin
			rt_data = i_wb_data;
		end
	end

	always_ff @(posedge i_clk) begin
		o_id_ex.next_pc <= i_if_id.next_pc;
		o_id_ex.rs_data <= rs_data;
		o_id_ex.rt_data <= rt_data;
		o_id_ex.imm <= imm_ext;
		o_id_ex.rt <= instr.r.rt;
		o_id_ex.rd <= instr.r.rd;
		if (i_reset) begin
			o_id_ex.ex_ctrl <= '0;
			o_id_ex.mem_ctrl <= '0;
			o_id_ex.wb_ctrl <= '0;
		end else begin
			o_id_ex.ex_ctrl <= ex_ctrl;
			o_id_ex.mem_ctrl <= mem_ctrl;
			o_id_ex.wb_ctrl <= wb_ctrl;
		end
	end

	// holds even while write-back targets register zero in the same cycle.
	a_zero_reads_zero: assert property (@(posedge i_clk) disable iff (i_reset)
		(instr.r.rs == '0) |=> (o_id_ex.rs_data == '0));

endmodule

// File: execute.sv
// execute stage with the ALU, the branch target adder and the EX/MEM register.
`timescale 1ns/1ps

module execute import mips_pkg::*; (
	input logic i_clk,
	input logic i_reset,
	input id_ex_t i_id_ex,

	output ex_mem_t o_ex_mem
);

	word_t operand_a;
	word_t operand_b;
	word_t alu_result;
	word_t branch_target;
	reg_addr_t dest;

	assign operand_a = i_id_ex.rs_data;
	assign operand_b = i_id_ex.ex_ctrl.alusrc ? i_id_ex.imm : i_id_ex.rt_data;

	always_comb begin
		case (i_id_ex.ex_ctrl.aluop)
			ALU_ADD: alu_result = operand_a + operand_b;
			ALU_SUB: alu_result = operand_a - operand_b;
			ALU_AND: alu_result = operand_a & operand_b;
			ALU_OR: alu_result = operand_a | operand_b;
			ALU_SLT: begin
				// signed compare.
				alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			end
			default: alu_result = '0;
		endcase
	end

	// the offset counts words relative to the instruction after the branch.
	assign branch_target = i_id_ex.next_pc + {i_id_ex.imm[29:0], 2'b00};

	assign dest = i_id_ex.ex_ctrl.regdst ? i_id_ex.rd : i_id_ex.rt;

	always_ff @(posedge i_clk) begin
		o_ex_mem.branch_target <= branch_target;
		o_ex_mem.zero <= (alu_result == '0);
		o_ex_mem.alu_result <= alu_result; // also the data address of lw and sw.
		o_ex_mem.rt_data <= i_id_ex.rt_data;
		o_ex_mem.dest <= dest;
		if (i_reset) begin
			o_ex_mem.mem_ctrl <= '0;
			o_ex_mem.wb_ctrl <= '0;
		end else begin
			o_ex_mem.mem_ctrl <= i_id_ex.mem_ctrl;
			o_ex_mem.wb_ctrl <= i_id_ex.wb_ctrl;
		end
	end

endmodule

// File: mem.sv
// memory stage with branch resolution, data memory access and write-back selection.
`timescale 1ns/1ps

module mem import mips_pkg::*; (
	input logic i_clk,
	input logic i_reset,
	input ex_mem_t i_ex_mem,
	input word_t i_read_data,

	output word_t o_data_address,
	output word_t o_write_data,
	output logic o_mem_write,
	output logic o_mem_read,
	output logic o_pc_src,
	output word_t o_branch_target,
	output logic o_wb_regwrite,
	output reg_addr_t o_wb_reg,
	output word_t o_wb_data
);

	mem_wb_t mem_wb;

	assign o_data_address = i_ex_mem.alu_result;
	assign o_write_data = i_ex_mem.rt_data;
	assign o_mem_write = i_ex_mem.mem_ctrl.memwrite;
	assign o_mem_read = i_ex_mem.mem_ctrl.memread;

	// fetch takes the target at the end of this cycle.
	assign o_pc_src = i_ex_mem.mem_ctrl.branch & i_ex_mem.zero;
	assign o_branch_target = i_ex_mem.branch_target;

	// load data arrives combinationally and is captured here.
	always_ff @(posedge i_clk) begin
		mem_wb.mem_data <= i_read_data;
		mem_wb.alu_result <= i_ex_mem.alu_result;
		mem_wb.dest <= i_ex_mem.dest;
		if (i_reset) begin
			mem_wb.wb_ctrl <= '0;
		end else begin
			mem_wb.wb_ctrl <= i_ex_mem.wb_ctrl;
		end
	end

	assign o_wb_regwrite = mem_wb.wb_ctrl.regwrite;
	assign o_wb_reg = mem_wb.dest;
	assign o_wb_data = mem_wb.wb_ctrl.memtoreg ? mem_wb.mem_data : mem_wb.alu_result;

	// decode never sets both strobes for one opcode.
	a_no_read_write: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_mem_read && o_mem_write));

endmodule

// File: core.sv
// five-stage MIPS pipeline core connecting fetch, decode, execute and memory stages.
`timescale 1ns/1ps

module core import mips_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic i_clk,
	input logic i_reset,
	input word_t i_read_instruction,
	input word_t i_read_data,

	output word_t o_instruction_address,
	output word_t o_data_address,
	output word_t o_write_data,
	output logic o_mem_write,
	output logic o_mem_read
);

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	logic pc_src;
	word_t branch_target;
	logic wb_regwrite; // write-back port into the register file.
	reg_addr_t wb_reg;
	word_t wb_data;

	fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_branch_target(branch_target),
		.i_pc_src(pc_src),
		.i_instruction(i_read_instruction),
		.o_pc(o_instruction_address),
		.o_if_id(if_id)
	);

	decode u_decode (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_if_id(if_id),
		.i_wb_regwrite(wb_regwrite),
		.i_wb_reg(wb_reg),
		.i_wb_data(wb_data),
		.o_id_ex(id_ex)
	);

	execute u_execute (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_id_ex(id_ex),
		.o_ex_mem(ex_mem)
	);

	mem u_mem (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ex_mem(ex_mem),
		.i_read_data(i_read_data),
		.o_data_address(o_data_address),
		.o_write_data(o_write_data),
		.o_mem_write(o_mem_write),
		.o_mem_read(o_mem_read),
		.o_pc_src(pc_src),
		.o_branch_target(branch_target),
		.o_wb_regwrite(wb_regwrite),
		.o_wb_reg(wb_reg),
		.o_wb_data(wb_data)
	);

endmodule

// File: core_tb.sv
// testbench for the mips pipeline core with memory models, pattern-driven stores and a timeout.
`timescale 1ns/1ps

module core_tb import mips_pkg::*; ();

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 256;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic clk;
	logic reset;
	word_t read_instruction;
	word_t read_data;
	word_t instruction_address;
	word_t data_address;
	word_t write_data;
	logic mem_write;
	logic mem_read;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	store_t expected [$];
	int prog_len = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	bit seen_store = 1'b0;

	core #(
		.RESET_PC(RESET_PC)
	) i_core (
		.i_clk(clk),
		.i_reset(reset),
		.i_read_instruction(read_instruction),
		.i_read_data(read_data),
		.o_instruction_address(instruction_address),
		.o_data_address(data_address),
		.o_write_data(write_data),
		.o_mem_write(mem_write),
		.o_mem_read(mem_read)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// both memories answer in the same cycle, and an unknown address reads as zero.
	always_comb begin
		if (instruction_address < IMEM_WORDS * 4) begin
			read_instruction = imem[instruction_address[7:2]];
		end else begin
			read_instruction = '0; // past the program only nops remain.
		end
	end

	// load data is driven only while the load strobe is high.
	always_comb begin
		if (mem_read && data_address < DMEM_WORDS * 4) begin
			read_data = dmem[data_address[9:2]];
		end else begin
			read_data = '0;
		end
	end

	task automatic finish_run(input bit ok);
		if (ok) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "simulation stopped at the first error");
		end
	endtask

	task automatic check_pc(input word_t expected_pc);
		if (instruction_address !== expected_pc) begin
			$display("ERR %0t: pc after reset is %h, expected %h", $time, instruction_address,
				expected_pc);
			finish_run(1'b0);
		end
	endtask

	task automatic check_store(input word_t addr, input word_t data);
		store_t exp;
		if (expected.size() == 0) begin
			$display("An extra store of %h to address %h came after the last expected store.",
				data, addr);
			finish_run(1'b0);
		end else begin
			exp = expected.pop_front();
			if (addr !== exp.addr) begin
				$display("ERR %0t: store address %h, expected %h", $time, addr, exp.addr);
				finish_run(1'b0);
			end else if (data !== exp.data) begin
				$display("ERR %0t: store data %h at %h, expected %h", $time, data, addr, exp.data);
				finish_run(1'b0);
			end
		end
	endtask

	// lines starting with # are comments; I and S lines carry an address and a word.
	task automatic load_patterns();
		int fd;
		int c;
		int n;
		word_t addr;
		word_t data;
		fd = $fopen("core_patterns.txt", "r");
		if (fd == 0) begin
			$display("The pattern file core_patterns.txt could not be opened.");
			finish_run(1'b0);
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != "\n" && c != -1) c = $fgetc(fd);
			end else if (c == "I" || c == "S") begin
				n = $fscanf(fd, "%h %h", addr, data);
				if (n != 2 || (c == "I" && addr >= IMEM_WORDS * 4)) begin
					$display("The pattern file holds a malformed line.");
					finish_run(1'b0);
				end
				if (c == "I") begin
					imem[addr[7:2]] = data;
					if (addr / 4 + 1 > prog_len) prog_len = addr / 4 + 1;
				end else begin
					expected.push_back({addr, data});
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("The run hit its limit of %0d cycles with %0d stores still expected.",
				cycle_limit, expected.size());
			finish_run(1'b0);
		end
	end

	// strobes are sampled mid-cycle, where they have settled.
	always @(negedge clk) begin
		if (cycle_count > 0) begin
			if ((^{mem_write, mem_read}) === 1'bx) begin
				$display("A data memory strobe is unknown at time %0t.", $time);
				finish_run(1'b0);
			end else if (reset && (mem_write || mem_read)) begin
				$display("A data memory strobe is high during reset at time %0t.", $time);
				finish_run(1'b0);
			end else if (!seen_store && mem_read) begin
				$display("A load strobe appeared before the first store at time %0t.", $time);
				finish_run(1'b0);
			end else if (mem_write) begin
				seen_store = 1'b1;
				dmem[data_address[9:2]] = write_data;
				check_store(data_address, write_data);
			end
		end
	end

	initial begin
		reset = 1'b1;
		foreach (imem[i]) imem[i] = '0;
		foreach (dmem[i]) dmem[i] = ~(i * 4); // each word starts as the inverse of its address.
		load_patterns();
		cycle_limit = 16 + 4 * prog_len + 40; // each program word gets four cycles of margin.
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		check_pc(RESET_PC);
		while (expected.size() != 0) @(posedge clk);
		repeat (10) @(posedge clk); // any store in this window is reported by the monitor.
		finish_run(1'b1);
	end

endmodule

// File: core_patterns.txt
# I <byte address> <instruction word>   program word, unlisted addresses hold nops
# S <byte address> <data word>          expected store, in the order it occurs
I 00 20010007
I 04 2002FFFD
I 10 00221820
I 14 00222022
I 18 00222824
I 1C 00223025
I 20 0041382A
I 24 AC030100
I 28 AC040104
I 2C AC050108
I 30 AC06010C
I 34 AC070110
I 38 8C08010C
I 44 01014820
I 50 AC090114
I 54 10210004
I 58 AC010118
I 64 AC02011C
I 68 10220004
I 6C AC020120
I 78 AC040124
I 7C 20000037
I 88 AC000128
S 100 00000004
S 104 0000000A
S 108 00000005
S 10C FFFFFFFF
S 110 00000001
S 114 00000006
S 118 00000007
S 120 FFFFFFFD
S 124 0000000A
S 128 00000000

// File: verilog.f
mips_pkg.sv
fetch.sv
decode.sv
execute.sv
mem.sv
core.sv
core_tb.sv
